// File: cpu.sv
//################################################
// cpu top level with the instruction sequencer
//################################################

`default_nettype none

`include "cpu_defs.svh"

module cpu (
  input  wire                     clk_in,
  input  wire                     rst_in,
  input  wire                     rdy_in,          // pause when low
  input  wire cpu_mem_pkg::byte_t mem_din,
  output cpu_mem_pkg::byte_t      mem_dout,
  output cpu_mem_pkg::addr_t      mem_a,
  output logic                    mem_wr,          // 1 for write
  input  wire                     io_buffer_full,
  output cpu_isa_pkg::word_t      dbgreg_dout
);
  import cpu_isa_pkg::*;
  import cpu_mem_pkg::*;

  typedef enum logic [2:0] {st_fetch, st_exec, st_mem, st_wb, st_halt} seq_state_t;

  seq_state_t   state;
  logic         boot;
  word_t        a_r;
  word_t        b_r;
  word_t        result_r;
  logic         taken_r;
  addr_t        target_r;
  logic         fetch_req;
  logic         fetch_ack;
  addr_t        fetch_addr;
  word_t        fetch_data;
  logic         ls_req;
  logic         ls_ack;
  logic         ls_write;
  addr_t        ls_addr;
  acc_size_t    ls_size;
  word_t        ls_wdata;
  word_t        ls_rdata;
  logic         fetch_start;
  logic         redirect;
  addr_t        redirect_pc;
  word_t        instr;
  logic         instr_valid;
  addr_t        pc;
  op_t          op;
  instr_class_t iclass;
  reg_idx_t     rs1;
  reg_idx_t     rs2;
  reg_idx_t     rd;
  word_t        imm;
  acc_size_t    mem_size;
  logic         load_unsigned;
  word_t        rs1_val;
  word_t        rs2_val;
  word_t        result;
  addr_t        mem_addr;
  logic         take_branch;
  addr_t        target;
  logic         lsu_start;
  logic         lsu_done;
  logic         lsu_stop;
  word_t        lsu_rdata;
  logic         rf_we;

  // decoded fields stay valid from instr_valid until the next fetch start
  assign fetch_start = boot || (state == st_wb);
  assign redirect    = (state == st_wb) && taken_r;
  assign redirect_pc = target_r;
  assign lsu_start   = (state == st_exec) && (iclass == cls_load || iclass == cls_store);
  assign rf_we       = (state == st_wb) &&
                       (iclass == cls_alu || iclass == cls_jump || iclass == cls_load);

  always_ff @(posedge clk_in)
  begin
    if (rst_in)
    begin
      state <= st_fetch;
      boot  <= 1'b1;  // kicks the first fetch
    end
    else if (rdy_in)
    begin
      boot <= 1'b0;
      case (state)
        st_fetch:
        begin
          if (instr_valid)
          begin
            a_r   <= rs1_val;
            b_r   <= instr[5] ? rs2_val : imm;  // opcode bit 5 marks register operand forms
            state <= st_exec;
          end
        end
        st_exec:
        begin
          result_r <= result;
          taken_r  <= take_branch;
          target_r <= target;
          state    <= lsu_start ? st_mem : st_wb;
        end
        st_mem:
        begin
          if (lsu_done)
          begin
            result_r <= lsu_rdata;
            state    <= lsu_stop ? st_halt : st_wb;
          end
        end
        st_wb:   state <= st_fetch;
        default: state <= st_halt;  // only reset leaves halt
      endcase
    end
  end

  mem_arbiter u_arbiter (.*);

  fetch_unit u_fetch (.*, .start(fetch_start));

  decoder u_decoder (.*);

  exec_unit u_exec (.*, .a(a_r), .b(b_r));

  regfile u_regfile (.*, .we(rf_we), .wdata(result_r));

  load_store_unit u_lsu (
    .*,
    .start    (lsu_start),
    .is_store (iclass == cls_store),
    .size     (mem_size),
    .addr     (mem_addr),
    .wdata    (b_r),
    .done     (lsu_done),
    .rdata    (lsu_rdata),
    .stop     (lsu_stop)
  );

endmodule

`default_nettype wire

// File: cpu_defs.svh
//################################################
// widths, memory map and debug register index
//################################################

`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

`define WORD_WIDTH    32
`define ADDR_WIDTH    32

`define REG_COUNT     32
`define REG_IDX_WIDTH 5

// main memory, 128KB from address 0
`define MEM_BYTES     32'h0002_0000

`define IO_OUT_ADDR   32'h0003_0000  // write a byte to output
`define IO_STOP_ADDR  32'h0003_0004  // write stops the program

`define DBG_REG       10  // a0

`endif

// File: cpu_isa_pkg.sv
//################################################
// opcode, operation and instruction class types
//################################################

`default_nettype none

`include "cpu_defs.svh"

package cpu_isa_pkg;

  typedef logic [`WORD_WIDTH-1:0]    word_t;
  typedef logic [`REG_IDX_WIDTH-1:0] reg_idx_t;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    opc_lui    = 7'b0110111,
    opc_op_imm = 7'b0010011,
    opc_op     = 7'b0110011,
    opc_branch = 7'b1100011,
    opc_jal    = 7'b1101111,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011
  } opcode_t;

  typedef enum logic [3:0] {
    op_lui, op_add, op_sub, op_and,
    op_or, op_xor, op_beq, op_bne,
    op_jal, op_load, op_store, op_nop
  } op_t;

  // path taken through the sequencer
  typedef enum logic [2:0] {
    cls_alu, cls_branch, cls_jump,
    cls_load, cls_store, cls_nop
  } instr_class_t;

endpackage

`default_nettype wire

// File: cpu_mem_pkg.sv
//################################################
// byte-wide memory bus types
//################################################

`default_nettype none

`include "cpu_defs.svh"

package cpu_mem_pkg;

  typedef logic [`ADDR_WIDTH-1:0] addr_t;
  typedef logic [7:0]             byte_t;

  typedef enum logic {
    acc_byte,
    acc_word
  } acc_size_t;

endpackage

`default_nettype wire

// File: cpu_patterns.txt
# t <mode>: new test, mode 1 drives rdy_in and io_buffer_full randomly
# p <word>: program word from address 0, o <byte>: expected output, r <word>: final x10
t 0
p 000300b7
p 00500113
p 00c00193
p 00310233
p 00408023
p 402182b3
p 00508023
p 00314333
p 00608023
p 003163b3
p 00708023
p 00317433
p 00808023
p fff00493
p 00908023
p 12345537
p 67850513
p 00a08023
p 00008223
o 11
o 07
o 09
o 0d
o 04
o ff
o 78
r 12345678
t 0
p 000300b7
p 00300113
p 00208023
p fff10113
p fe011ce3
p 00c0056f
p 00108023
p 00208023
p 00a08023
p 00000463
p 00108023
p 00008223
o 03
o 02
o 01
o 18
r 00000018
t 0
p 000300b7
p 00001137
p a1b2c1b7
p 3d418193
p 00312023
p 00012203
p 00408023
p 00314283
p 00508023
p 08000313
p 00610423
p 00810383
p 00814403
p 0083c533
p 00708023
p 00808023
p 00008223
o d4
o a1
o 80
o 80
r ffffff00
t 1
p 000300b7
p 00500113
p 00c00193
p 00310233
p 00408023
p 402182b3
p 00508023
p 00314333
p 00608023
p 003163b3
p 00708023
p 00317433
p 00808023
p fff00493
p 00908023
p 12345537
p 67850513
p 00a08023
p 00008223
o 11
o 07
o 09
o 0d
o 04
o ff
o 78
r 12345678

// File: decoder.sv
//################################################
// field extraction, immediates and operation select
//################################################

`default_nettype none

`include "cpu_defs.svh"

module decoder (
  input  wire cpu_isa_pkg::word_t     instr,
  output cpu_isa_pkg::op_t            op,
  output cpu_isa_pkg::instr_class_t   iclass,
  output cpu_isa_pkg::reg_idx_t       rs1,
  output cpu_isa_pkg::reg_idx_t       rs2,
  output cpu_isa_pkg::reg_idx_t       rd,
  output cpu_isa_pkg::word_t          imm,
  output cpu_mem_pkg::acc_size_t      mem_size,
  output logic                        load_unsigned
);
  import cpu_isa_pkg::*;
  import cpu_mem_pkg::*;

  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;

  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rd     = instr[11:7];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  assign load_unsigned = funct3[2];  // lbu
  assign mem_size      = (funct3[1:0] == 2'b10) ? acc_word : acc_byte;

  always_comb
  begin
    op     = op_nop;
    iclass = cls_nop;
    imm    = imm_i;
    case (opcode_t'(instr[6:0]))
      opc_lui:
      begin
        op     = op_lui;
        iclass = cls_alu;
        imm    = imm_u;
      end
      opc_op_imm:
      begin
        if (funct3 == 3'b000)  // addi only
        begin
          op     = op_add;
          iclass = cls_alu;
        end
      end
      opc_op:
      begin
        iclass = cls_alu;
        if (funct7 == 7'b0100000 && funct3 == 3'b000)
          op = op_sub;
        else if (funct7 == 7'b0000000 && funct3 == 3'b000)
          op = op_add;
        else if (funct7 == 7'b0000000 && funct3 == 3'b100)
          op = op_xor;
        else if (funct7 == 7'b0000000 && funct3 == 3'b110)
          op = op_or;
        else if (funct7 == 7'b0000000 && funct3 == 3'b111)
          op = op_and;
        else
          iclass = cls_nop;
      end
      opc_branch:
      begin
        imm = imm_b;
        if (funct3 == 3'b000 || funct3 == 3'b001)
        begin
          op     = funct3[0] ? op_bne : op_beq;
          iclass = cls_branch;
        end
      end
      opc_jal:
      begin
        op     = op_jal;
        iclass = cls_jump;
        imm    = imm_j;
      end
      opc_load:
      begin
        if (funct3 == 3'b000 || funct3 == 3'b100 || funct3 == 3'b010)
        begin
          op     = op_load;
          iclass = cls_load;
        end
      end
      opc_store:
      begin
        imm = imm_s;
        if (funct3 == 3'b000 || funct3 == 3'b010)
        begin
          op     = op_store;
          iclass = cls_store;
        end
      end
      default:
        op = op_nop;  // anything else retires as a no-op
    endcase
  end

endmodule

`default_nettype wire

// File: exec_unit.sv
//################################################
// alu, branch compare and address computation
//################################################

`default_nettype none

`include "cpu_defs.svh"

module exec_unit (
  input  wire cpu_isa_pkg::op_t   op,
  input  wire cpu_isa_pkg::word_t a,
  input  wire cpu_isa_pkg::word_t b,
  input  wire cpu_isa_pkg::word_t imm,
  input  wire cpu_mem_pkg::addr_t pc,
  output cpu_isa_pkg::word_t      result,
  output cpu_mem_pkg::addr_t      mem_addr,
  output logic                    take_branch,
  output cpu_mem_pkg::addr_t      target
);
  import cpu_isa_pkg::*;

  assign mem_addr = a + imm;
  assign target   = pc + imm;  // branch and jal share the pc-relative form

  always_comb
  begin
    result      = a + b;
    take_branch = 1'b0;
    case (op)
      op_lui: result = imm;
      op_sub: result = a - b;
      op_and: result = a & b;
      op_or:  result = a | b;
      op_xor: result = a ^ b;
      op_beq: take_branch = (a == b);
      op_bne: take_branch = (a != b);
      op_jal:
      begin
        result      = pc + 32'd4;  // link value
        take_branch = 1'b1;
      end
      default: result = a + b;
    endcase
  end

endmodule

`default_nettype wire

// File: fetch_unit.sv
//################################################
// program counter and instruction fetch
//################################################

`default_nettype none

`include "cpu_defs.svh"

module fetch_unit (
  input  wire                     clk_in,
  input  wire                     rst_in,
  input  wire                     rdy_in,
  input  wire                     start,
  input  wire                     redirect,
  input  wire cpu_mem_pkg::addr_t redirect_pc,
  output logic                    fetch_req,
  output cpu_mem_pkg::addr_t      fetch_addr,
  input  wire                     fetch_ack,
  input  wire cpu_isa_pkg::word_t fetch_data,
  output cpu_isa_pkg::word_t      instr,
  output logic                    instr_valid,
  output cpu_mem_pkg::addr_t      pc
);

  logic advance;  // low until the first instruction has been fetched

  assign fetch_addr = pc;

  always_ff @(posedge clk_in)
  begin
    if (rst_in)
    begin
      pc          <= '0;
      advance     <= 1'b0;
      fetch_req   <= 1'b0;
      instr_valid <= 1'b0;
    end
    else if (rdy_in)
    begin
      if (start)
      begin
        fetch_req   <= 1'b1;
        instr_valid <= 1'b0;
        advance     <= 1'b1;
        if (redirect)
          pc <= redirect_pc;
        else if (advance)
          pc <= pc + 32'd4;
      end
      else if (fetch_req && fetch_ack)
      begin
        fetch_req   <= 1'b0;
        instr       <= fetch_data;
        instr_valid <= 1'b1;
      end
    end
  end

  a_pc_aligned: assert property (@(posedge clk_in) disable iff (rst_in)
    fetch_req |-> (pc[1:0] == 2'b00));

endmodule

`default_nettype wire

// File: load_store_unit.sv
//################################################
// load/store requests, byte extension, stop detect
//################################################

`default_nettype none

`include "cpu_defs.svh"

module load_store_unit (
  input  wire                         clk_in,
  input  wire                         rst_in,
  input  wire                         rdy_in,
  input  wire                         start,
  input  wire                         is_store,
  input  wire cpu_mem_pkg::acc_size_t size,
  input  wire                         load_unsigned,
  input  wire cpu_mem_pkg::addr_t     addr,
  input  wire cpu_isa_pkg::word_t     wdata,
  output logic                        done,
  output cpu_isa_pkg::word_t          rdata,
  output logic                        stop,
  output logic                        ls_req,
  output cpu_mem_pkg::addr_t          ls_addr,
  output cpu_mem_pkg::acc_size_t      ls_size,
  output logic                        ls_write,
  output cpu_isa_pkg::word_t          ls_wdata,
  input  wire                         ls_ack,
  input  wire cpu_isa_pkg::word_t     ls_rdata
);
  import cpu_isa_pkg::*;
  import cpu_mem_pkg::*;

  logic  unsigned_r;
  word_t load_val;

  always_comb
  begin
    if (ls_size == acc_word)
      load_val = ls_rdata;
    else if (unsigned_r)
      load_val = {24'b0, ls_rdata[7:0]};
    else
      load_val = {{24{ls_rdata[7]}}, ls_rdata[7:0]};  // lb
  end

  always_ff @(posedge clk_in)
  begin
    if (rst_in)
    begin
      ls_req <= 1'b0;
      done   <= 1'b0;
      stop   <= 1'b0;
    end
    else if (rdy_in)
    begin
      done <= 1'b0;
      stop <= 1'b0;
      if (start)
      begin
        ls_req     <= 1'b1;
        ls_addr    <= addr;
        ls_size    <= size;
        ls_write   <= is_store;
        ls_wdata   <= wdata;
        unsigned_r <= load_unsigned;
      end
      else if (ls_req && ls_ack)
      begin
        ls_req <= 1'b0;
        done   <= 1'b1;
        rdata  <= load_val;
        stop   <= ls_write && (ls_addr == `IO_STOP_ADDR);
      end
    end
  end

endmodule

`default_nettype wire

// File: mem_arbiter.sv
//################################################
// memory bus master shared by fetch and load/store
//################################################

`default_nettype none

`include "cpu_defs.svh"

module mem_arbiter (
  input  wire                            clk_in,
  input  wire                            rst_in,
  input  wire                            rdy_in,
  input  wire                            fetch_req,
  input  wire cpu_mem_pkg::addr_t        fetch_addr,
  output logic                           fetch_ack,
  output cpu_isa_pkg::word_t             fetch_data,
  input  wire                            ls_req,
  input  wire cpu_mem_pkg::addr_t        ls_addr,
  input  wire cpu_mem_pkg::acc_size_t    ls_size,
  input  wire                            ls_write,
  input  wire cpu_isa_pkg::word_t        ls_wdata,
  output logic                           ls_ack,
  output cpu_isa_pkg::word_t             ls_rdata,
  input  wire cpu_mem_pkg::byte_t        mem_din,
  output cpu_mem_pkg::byte_t             mem_dout,
  output cpu_mem_pkg::addr_t             mem_a,
  output logic                           mem_wr,
  input  wire                            io_buffer_full
);
  import cpu_isa_pkg::*;
  import cpu_mem_pkg::*;

  logic       busy;
  logic       ack_r;
  logic       grant_ls;
  logic       write_r;
  acc_size_t  size_r;
  addr_t      addr_r;
  word_t      wdata_r;
  word_t      word_r;
  logic [2:0] cnt;
  logic [2:0] last;
  logic       io_hold;

  assign last    = (size_r == acc_word) ? 3'd3 : 3'd0;
  assign io_hold = io_buffer_full && (addr_r >= `IO_OUT_ADDR);  // uart cannot take more

  assign mem_a    = addr_r + addr_t'(cnt);
  assign mem_dout = wdata_r[7:0];
  assign mem_wr   = rdy_in && busy && write_r && !io_hold;

  assign fetch_ack  = ack_r && !grant_ls;
  assign ls_ack     = ack_r && grant_ls;
  assign fetch_data = word_r;
  assign ls_rdata   = (size_r == acc_word) ? word_r : {24'b0, word_r[31:24]};

  always_ff @(posedge clk_in)
  begin
    if (rst_in)
    begin
      busy     <= 1'b0;
      ack_r    <= 1'b0;
      grant_ls <= 1'b0;
      cnt      <= 3'd0;
      addr_r   <= '0;
    end
    else if (rdy_in)
    begin
      if (ack_r)
      begin
        if (!(grant_ls ? ls_req : fetch_req))
          ack_r <= 1'b0;
      end
      else if (busy)
      begin
        if (write_r)
        begin
          if (!io_hold)
          begin
            wdata_r <= wdata_r >> 8;
            cnt     <= cnt + 3'd1;
            if (cnt == last)
            begin
              busy  <= 1'b0;
              ack_r <= 1'b1;
            end
          end
        end
        else
        begin
          if (cnt != 3'd0)
            word_r <= {mem_din, word_r[31:8]};  // byte for cnt-1 arrives now
          cnt <= cnt + 3'd1;
          if (cnt == last + 3'd1)
          begin
            busy  <= 1'b0;
            ack_r <= 1'b1;
          end
        end
      end
      else if (ls_req || fetch_req)
      begin
        busy     <= 1'b1;
        grant_ls <= ls_req;  // load/store wins a tie
        cnt      <= 3'd0;
        addr_r   <= ls_req ? ls_addr : fetch_addr;
        size_r   <= ls_req ? ls_size : acc_word;
        write_r  <= ls_req && ls_write;
        wdata_r  <= ls_wdata;
      end
    end
  end

  a_ack_with_req: assert property (@(posedge clk_in) disable iff (rst_in)
    $rose(ack_r) |-> (grant_ls ? ls_req : fetch_req));
  a_ls_req_held: assert property (@(posedge clk_in) disable iff (rst_in)
    (ls_req && !ls_ack) |=> (ls_req && $stable(ls_addr)));

endmodule

`default_nettype wire

// File: regfile.sv
//################################################
// register file with debug read port
//################################################

`default_nettype none

`include "cpu_defs.svh"

module regfile (
  input  wire                        clk_in,
  input  wire                        rst_in,
  input  wire                        rdy_in,
  input  wire cpu_isa_pkg::reg_idx_t rs1,
  input  wire cpu_isa_pkg::reg_idx_t rs2,
  output cpu_isa_pkg::word_t         rs1_val,
  output cpu_isa_pkg::word_t         rs2_val,
  input  wire                        we,
  input  wire cpu_isa_pkg::reg_idx_t rd,
  input  wire cpu_isa_pkg::word_t    wdata,
  output cpu_isa_pkg::word_t         dbgreg_dout
);
  import cpu_isa_pkg::*;

  word_t regs [`REG_COUNT];

  always_ff @(posedge clk_in)
  begin
    if (rst_in)
    begin
      for (int i = 0; i < `REG_COUNT; i++)
        regs[i] <= '0;
    end
    else if (rdy_in && we && rd != '0)  // x0 stays zero
      regs[rd] <= wdata;
  end

  assign rs1_val     = regs[rs1];
  assign rs2_val     = regs[rs2];
  assign dbgreg_dout = regs[`DBG_REG];

  a_x0_zero: assert property (@(posedge clk_in) disable iff (rst_in)
    (rs1 == '0) |-> (rs1_val == '0));

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the cpu testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -Wno-fatal --top-module tb_cpu \
  -f sim.f -o tb_cpu_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_cpu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulator exited with status $status"
  exit 1
fi

if grep -q "^Simulation completed successfully$" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1

// File: sim.f
+incdir+.
cpu_isa_pkg.sv
cpu_mem_pkg.sv
mem_arbiter.sv
fetch_unit.sv
decoder.sv
exec_unit.sv
regfile.sv
load_store_unit.sv
cpu.sv
tb_cpu.sv

// File: tb_cpu.sv
//################################################
// testbench for cpu with memory model and checks
//################################################

`default_nettype none

`include "cpu_defs.svh"

module tb_cpu;

  localparam int HALT_TIMEOUT = 20000;  // cycles allowed per program
  localparam int QUIET_WINDOW = 40;     // cycles watched after the stop write
  localparam logic [31:0] GUARD_WORD = 32'h0000_2023;  // sw x0, 0(x0)

  logic        clk_in;
  logic        rst_in;
  logic        rdy_in;
  logic        io_buffer_full;
  logic [7:0]  mem_din;
  logic [7:0]  mem_dout;
  logic [31:0] mem_a;
  logic        mem_wr;
  logic [31:0] dbgreg_dout;

  logic [7:0]  mem [0:`MEM_BYTES-1];
  logic [7:0]  tags [$];
  logic [31:0] vals [$];
  logic [7:0]  out_bytes [$];
  logic [7:0]  exp_bytes [$];

  integer seed;
  logic   rand_mode;
  logic   stop_seen;
  int     late_writes;
  int     errors;
  int     tests_run;
  int     tests_failed;

  cpu u_cpu (
    .clk_in         (clk_in),
    .rst_in         (rst_in),
    .rdy_in         (rdy_in),
    .mem_din        (mem_din),
    .mem_dout       (mem_dout),
    .mem_a          (mem_a),
    .mem_wr         (mem_wr),
    .io_buffer_full (io_buffer_full),
    .dbgreg_dout    (dbgreg_dout)
  );

  initial
  begin
    clk_in = 1'b0;
    forever #50 clk_in = ~clk_in;
  end

  // pause and back-pressure pattern
  always @(posedge clk_in)
  begin
    #10;
    if (rand_mode)
    begin
      rdy_in         = (($random(seed) & 3) != 0);
      io_buffer_full = (($random(seed) & 3) == 0);
    end
    else
    begin
      rdy_in         = 1'b1;
      io_buffer_full = 1'b0;
    end
  end

  // writes land at the edge and read data follows the previous active address
  always @(posedge clk_in)
  begin : mem_model
    logic [31:0] rd_addr;
    rd_addr = mem_a;
    if (!rst_in && mem_wr)
    begin
      assert (rdy_in)
      else
      begin
        $display("write to %h issued while rdy_in was low", mem_a);
        errors++;
      end
      if (mem_a >= `IO_OUT_ADDR)
      begin
        assert (!io_buffer_full)
        else
        begin
          $display("I/O write to %h issued while io_buffer_full was high", mem_a);
          errors++;
        end
      end
      if (stop_seen)
        late_writes++;
      else if (mem_a == `IO_OUT_ADDR)
        out_bytes.push_back(mem_dout);
      else if (mem_a == `IO_STOP_ADDR)
        stop_seen = 1'b1;
      else if (mem_a < `MEM_BYTES)
        mem[mem_a] = mem_dout;
    end
    if (rdy_in)
    begin
      #10;
      mem_din = (rd_addr < `MEM_BYTES) ? mem[rd_addr] : 8'h00;
    end
  end

  task automatic wait_cycle();
    @(posedge clk_in);
    #10;
  endtask

  task automatic load_patterns();
    int          fd;
    int          n;
    string       line;
    logic [7:0]  tag;
    logic [31:0] val;
    fd = $fopen("cpu_patterns.txt", "r");
    if (fd == 0)
    begin
      $display("could not open cpu_patterns.txt");
      errors++;
    end
    else
    begin
      while (!$feof(fd))
      begin
        line = "";
        n = $fgets(line, fd);
        if (n > 0 && line.len() > 0 && line[0] != "#")
        begin
          n = $sscanf(line, "%c %h", tag, val);
          if (n == 2)
          begin
            tags.push_back(tag);
            vals.push_back(val);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic run_test(inout int idx);
    logic [31:0] exp_reg;
    int          addr;
    int          cycles;
    int          errs_before;
    errs_before = errors;
    tests_run++;
    rand_mode = vals[idx][0];
    idx++;
    rst_in = 1'b1;
    for (int a = 0; a < `MEM_BYTES; a++)
      mem[a] = 8'(a ^ (a >> 8) ^ (a >> 16));
    exp_bytes.delete();
    out_bytes.delete();
    stop_seen   = 1'b0;
    late_writes = 0;
    exp_reg     = '0;
    addr        = 0;
    while (idx < tags.size() && tags[idx] != "t")
    begin
      case (tags[idx])
        "p":
        begin
          for (int k = 0; k < 4; k++)
            mem[addr + k] = vals[idx][8*k +: 8];  // little endian
          addr += 4;
        end
        "o":     exp_bytes.push_back(vals[idx][7:0]);
        "r":     exp_reg = vals[idx];
        default:
        begin
          $display("unknown pattern tag %c", tags[idx]);
          errors++;
        end
      endcase
      idx++;
    end
    // a core that runs past the stop writes memory here
    for (int k = 0; k < 4; k++)
      mem[addr + k] = GUARD_WORD[8*k +: 8];
    repeat (3) wait_cycle();
    rst_in = 1'b0;
    cycles = 0;
    while (!stop_seen && cycles < HALT_TIMEOUT)
    begin
      wait_cycle();
      cycles++;
    end
    if (!stop_seen)
    begin
      $display("test %0d: core did not halt", tests_run);
      errors++;
    end
    else
    begin
      cycles = 0;
      while (cycles < QUIET_WINDOW)
      begin
        wait_cycle();
        cycles++;
      end
      assert (late_writes == 0)
      else
      begin
        $display("core kept writing memory after the stop write (%0d writes)", late_writes);
        errors++;
      end
      assert (out_bytes.size() == exp_bytes.size())
      else
      begin
        $display("Mismatch output byte count: got %h expected %h",
                 out_bytes.size(), exp_bytes.size());
        errors++;
      end
      for (int i = 0; i < exp_bytes.size() && i < out_bytes.size(); i++)
      begin
        assert (out_bytes[i] == exp_bytes[i])
        else
        begin
          $display("Mismatch mem_dout byte %0d: got %h expected %h",
                   i, out_bytes[i], exp_bytes[i]);
          errors++;
        end
      end
      assert (dbgreg_dout == exp_reg)
      else
      begin
        $display("Mismatch dbgreg_dout: got %h expected %h", dbgreg_dout, exp_reg);
        errors++;
      end
    end
    if (errors != errs_before)
      tests_failed++;
    $display("test %0d%s: %s", tests_run, rand_mode ? " (random pause)" : "",
             (errors == errs_before) ? "ok" : "FAILED");
  endtask

  initial
  begin : main
    int idx;
    rst_in         = 1'b1;
    rdy_in         = 1'b1;
    io_buffer_full = 1'b0;
    mem_din        = 8'h00;
    rand_mode      = 1'b0;
    stop_seen      = 1'b0;
    seed           = 76748;
    errors         = 0;
    tests_run      = 0;
    tests_failed   = 0;
    late_writes    = 0;
    load_patterns();
    wait_cycle();
    idx = 0;
    while (idx < tags.size())
    begin
      if (tags[idx] == "t")
        run_test(idx);
      else
        idx++;  // stray line before the first test
    end
    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0 && tests_run > 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire
